// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_dcu_arbiter
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_dcu_arbiter.sv
`timescale 1ns/10ps
`include "dcu_defines.svh"

module tb_dcu_arbiter;

    // Two 256-byte fetches at about 20 cycles per word, stretched by busy, four times over
    localparam int TIMEOUT_CYCLES = 200000;

    logic                   CLK = 1'b0;
    logic                   rst;
    dcu_pkg::host_req_t     host;
    logic [7:0]             host_rdata;
    logic [`DCU_ROM_AW-1:0] rom_addr;
    logic                   rom_rd;
    logic [15:0]            rom_data;
    logic                   rom_busy;
    logic                   dcu_start;
    logic [1:0]             dcu_mode;

    logic [15:0]            rom_mem [0:65535];
    logic                   busy_on = 1'b0;
    logic                   prev_rd = 1'b0;
    logic [`DCU_ROM_AW-1:0] prev_addr = '0;
    int                     cycles = 0;
    int                     mismatch_cnt = 0;
    int                     other_cnt = 0;
    logic [23:0]            base;
    logic [7:0]             idx_odd;
    logic [7:0]             idx_even;

    dcu_arbiter i_dcu_arbiter (
        .CLK(CLK), .rst(rst), .host(host), .host_rdata(host_rdata), .rom_addr(rom_addr),
        .rom_rd(rom_rd), .rom_data(rom_data), .rom_busy(rom_busy), .dcu_start(dcu_start),
        .dcu_mode(dcu_mode)
    );

    always #5 CLK = ~CLK;

    ////////////////////////////////////////
    // ROM model
    ////////////////////////////////////////

    // Only the low 16 word address bits are decoded
    assign rom_data = rom_mem[rom_addr[15:0]];

    // Higher priority reader, about 30 percent of cycles when enabled
    initial begin
        rom_busy = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            rom_busy = busy_on && ($urandom_range(99) < 30);
        end
    end

    // Address must hold for the whole access
    always @(negedge CLK) begin
        if (rom_rd && prev_rd && (rom_addr != prev_addr)) begin
            $display("ERROR: rom_addr changed while rom_rd was high at %0t", $time);
            other_cnt++;
        end
        prev_rd   <= rom_rd;
        prev_addr <= rom_addr;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: mismatch=%0d other=%0d", mismatch_cnt, other_cnt + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Even byte in the high half of the word, odd byte in the low half
    function automatic logic [7:0] exp_byte(input logic [23:0] a);
        logic [15:0] w;
        w = rom_mem[a[16:1]];
        return a[0] ? w[7:0] : w[15:8];
    endfunction

    // Pointer is entry bytes 1 to 3, MSB first
    function automatic logic [23:0] exp_ptr(input logic [23:0] b, input logic [7:0] index);
        logic [23:0] ea;
        ea = b + {14'd0, index, 2'b00};
        return {exp_byte(ea + 24'd1), exp_byte(ea + 24'd2), exp_byte(ea + 24'd3)};
    endfunction

    function automatic logic [7:0] pick_index(input logic [23:0] b, input logic odd);
        logic [23:0] p;
        for (int i = 0; i < 256; i++) begin
            p = exp_ptr(b, 8'(i));
            if (p[0] == odd) begin
                return 8'(i);
            end
        end
        return 8'h00;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_mode(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s mode: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s count: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // Host bus
    ////////////////////////////////////////

    task automatic host_write(input logic [3:0] port, input logic [7:0] data);
        host = '{rd: 1'b0, wr: 1'b1, port: port, wdata: data};
        @(posedge CLK);
        #1;
        host = '0;
    endtask

    // Registered read data is there one cycle after the pulse
    task automatic host_read(input logic [3:0] port, output logic [7:0] data);
        host = '{rd: 1'b1, wr: 1'b0, port: port, wdata: 8'h00};
        @(posedge CLK);
        #1;
        host = '0;
        data = host_rdata;
    endtask

    task automatic wait_ready();
        logic [7:0] st;
        st = 8'h00;
        while (st != `DCU_STATUS_READY) begin
            host_read(`DCU_PORT_STATUS, st);
        end
    endtask

    task automatic readback(input string name, input logic [3:0] port, input logic [7:0] val);
        logic [7:0] d;
        host_write(port, val);
        host_read(port, d);
        check_byte(name, val, d);
    endtask

    // Fetch one entry, drain nbytes and check the length counter
    task automatic run_stream(input string name, input logic [23:0] b, input logic [7:0] index,
                              input int nbytes, input logic [15:0] load);
        logic [23:0] ea;
        logic [23:0] ptr;
        logic [7:0]  d;
        logic [7:0]  hi;
        ea  = b + {14'd0, index, 2'b00};
        ptr = exp_ptr(b, index);
        host_write(`DCU_PORT_BASE0, b[7:0]);
        host_write(`DCU_PORT_BASE1, b[15:8]);
        host_write(`DCU_PORT_BASE2, b[23:16]);
        host_write(`DCU_PORT_COUNTER0, load[7:0]);
        host_write(`DCU_PORT_COUNTER1, load[15:8]);
        host_write(`DCU_PORT_INDEX, index);
        // Flush lands one cycle after the start pulse
        @(posedge CLK);
        #1;
        host_read(`DCU_PORT_STATUS, d);
        check_byte({name, "_status"}, 8'h00, d);
        while (!dcu_start) begin
            @(posedge CLK);
            #1;
        end
        d = exp_byte(ea);
        check_mode(name, d[1:0], dcu_mode);
        for (int i = 0; i < nbytes; i++) begin
            wait_ready();
            host_read(`DCU_PORT_READ, d);
            check_byte(name, exp_byte(ptr + 24'(i)), d);
        end
        host_read(`DCU_PORT_COUNTER0, d);
        host_read(`DCU_PORT_COUNTER1, hi);
        check_count(name, load - 16'(nbytes), {hi, d});
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [7:0] lo;
        logic [7:0] hi;
        void'($urandom(32'hcb33_ee8c));
        rst  = 1'b1;
        host = '0;
        for (int i = 0; i < 65536; i++) begin
            rom_mem[i] = 16'($urandom);
        end
        repeat (4) @(posedge CLK);
        #1;
        rst = 1'b0;

        // Register readback
        readback("base0", `DCU_PORT_BASE0, 8'h34);
        readback("base1", `DCU_PORT_BASE1, 8'h12);
        readback("base2", `DCU_PORT_BASE2, 8'h00);
        readback("index", `DCU_PORT_INDEX, 8'h07);
        host_write(`DCU_PORT_COUNTER0, 8'ha5);
        host_write(`DCU_PORT_COUNTER1, 8'h5a);
        host_read(`DCU_PORT_COUNTER0, lo);
        host_read(`DCU_PORT_COUNTER1, hi);
        check_count("counter_readback", 16'h5aa5, {hi, lo});

        // Streams from odd and even pointers, second one wraps the counter
        base     = 24'h00_4a10;
        idx_odd  = pick_index(base, 1'b1);
        idx_even = pick_index(base, 1'b0);
        run_stream("stream_odd", base, idx_odd, 256, 16'h0105);
        run_stream("stream_even", base, idx_even, 256, 16'h0040);

        // Same streams with the ROM preempted
        busy_on = 1'b1;
        run_stream("busy_odd", base, idx_odd, 256, 16'h0300);
        run_stream("busy_even", base, idx_even, 256, 16'hffff);
        busy_on = 1'b0;

        // Restart in the middle of a stream
        run_stream("restart_old", base, idx_odd, 16, 16'h1000);
        run_stream("restart_new", base, idx_even, 256, 16'h1000);

        $display("errors: mismatch=%0d other=%0d", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: include/dcu_defines.svh
`ifndef DCU_DEFINES_SVH
`define DCU_DEFINES_SVH

////////////////////////////////////////
// ROM timing and widths
////////////////////////////////////////

// Cycles a ROM read must run with the bus free
`define DCU_ROM_WAIT 4'd7

// Word address into the 16-bit ROM
`define DCU_ROM_AW 23

// Byte pointer into ROM space
`define DCU_PTR_W 24

// Prefetch ring depth is 2**DCU_RING_AW bytes
`define DCU_RING_AW 10

////////////////////////////////////////
// Host port map
////////////////////////////////////////

`define DCU_PORT_READ     4'h0
`define DCU_PORT_BASE0    4'h1
`define DCU_PORT_BASE1    4'h2
`define DCU_PORT_BASE2    4'h3
`define DCU_PORT_INDEX    4'h4
`define DCU_PORT_COUNTER0 4'h9
`define DCU_PORT_COUNTER1 4'hA
`define DCU_PORT_STATUS   4'hC

// Status value while the ring holds data
`define DCU_STATUS_READY 8'h80

`endif

// File: tb.f
+incdir+include
verilog/dcu_pkg.sv
verilog/rom_port.sv
verilog/dir_fetch.sv
verilog/rom_prefetch.sv
verilog/byte_ring.sv
verilog/host_regs.sv
verilog/dcu_arbiter.sv
bench/tb_dcu_arbiter.sv

// File: verilog/byte_ring.sv
`timescale 1ns/10ps
`include "dcu_defines.svh"

module byte_ring (
    input  logic              CLK,
    input  logic              rst,
    input  logic              flush,
    input  dcu_pkg::ring_wr_t wr,
    input  logic              rd,
    output logic [7:0]        rdata,
    output logic              empty,
    output logic              two_free
);
    logic [7:0]              mem [0:(1 << `DCU_RING_AW)-1];
    logic [`DCU_RING_AW-1:0] wr_ptr;
    logic [`DCU_RING_AW-1:0] rd_ptr;
    logic [`DCU_RING_AW-1:0] free_cnt;

    // One slot stays unused so full and empty differ
    assign free_cnt = rd_ptr - wr_ptr - 1'b1;
    assign empty    = (rd_ptr == wr_ptr);
    assign two_free = (free_cnt >= `DCU_RING_AW'(2));

    // Head byte, valid while not empty
    assign rdata = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr.we && !flush) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    // Prefetch back-pressure must keep the ring from overflowing
    a_no_overflow: assert property (@(posedge CLK) disable iff (rst || flush)
        wr.we |-> (free_cnt != '0))
        else $error("byte_ring: write while full");
    // Host side must not pop an empty ring
    a_no_underflow: assert property (@(posedge CLK) disable iff (rst || flush) rd |-> !empty)
        else $error("byte_ring: read while empty");

endmodule

// File: verilog/dcu_arbiter.sv
`timescale 1ns/10ps
`include "dcu_defines.svh"

module dcu_arbiter (
    input  logic                   CLK,
    input  logic                   rst,
    input  dcu_pkg::host_req_t     host,
    output logic [7:0]             host_rdata,
    output logic [`DCU_ROM_AW-1:0] rom_addr,
    output logic                   rom_rd,
    input  logic [15:0]            rom_data,
    input  logic                   rom_busy,
    output logic                   dcu_start,
    output logic [1:0]             dcu_mode
);
    dcu_pkg::dir_req_t   dir;
    dcu_pkg::dir_entry_t entry;
    dcu_pkg::rom_req_t   dir_rom_req;
    dcu_pkg::rom_req_t   pf_rom_req;
    dcu_pkg::rom_rsp_t   dir_rom_rsp;
    dcu_pkg::rom_rsp_t   pf_rom_rsp;
    dcu_pkg::ring_wr_t   ring_wr;
    logic                ring_rd;
    logic                ring_empty;
    logic                ring_two_free;
    logic [7:0]          ring_rdata;

    assign dcu_mode = entry.mode;

    host_regs i_host_regs (
        .CLK(CLK), .rst(rst), .host(host), .ring_empty(ring_empty), .ring_rdata(ring_rdata),
        .ring_rd(ring_rd), .dir(dir), .host_rdata(host_rdata)
    );

    dir_fetch i_dir_fetch (
        .CLK(CLK), .rst(rst), .dir(dir), .rom_req(dir_rom_req), .rom_rsp(dir_rom_rsp),
        .entry(entry), .done(dcu_start)
    );

    rom_port i_rom_port (
        .CLK(CLK), .rst(rst), .dir_req(dir_rom_req), .pf_req(pf_rom_req),
        .dir_rsp(dir_rom_rsp), .pf_rsp(pf_rom_rsp), .rom_busy(rom_busy),
        .rom_addr(rom_addr), .rom_rd(rom_rd), .rom_data(rom_data)
    );

    // New fetch start also flushes the prefetch path
    rom_prefetch i_rom_prefetch (
        .CLK(CLK), .rst(rst), .flush(dir.start), .done(dcu_start), .entry(entry),
        .ring_two_free(ring_two_free), .rom_req(pf_rom_req), .rom_rsp(pf_rom_rsp),
        .ring_wr(ring_wr)
    );

    byte_ring i_byte_ring (
        .CLK(CLK), .rst(rst), .flush(dir.start), .wr(ring_wr), .rd(ring_rd),
        .rdata(ring_rdata), .empty(ring_empty), .two_free(ring_two_free)
    );

endmodule

// File: verilog/dcu_pkg.sv
`include "dcu_defines.svh"

package dcu_pkg;

    // One host bus cycle
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic [3:0] port;
        logic [7:0] wdata;
    } host_req_t;

    // Directory fetch request from the host registers
    typedef struct packed {
        logic                  start;
        logic [`DCU_PTR_W-1:0] base;
        logic [7:0]            index;
    } dir_req_t;

    // Decoded directory entry
    typedef struct packed {
        logic [1:0]            mode;
        logic [`DCU_PTR_W-1:0] ptr;
    } dir_entry_t;

    // Client side of the shared ROM
    typedef struct packed {
        logic                   req;
        logic [`DCU_ROM_AW-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] data;
    } rom_rsp_t;

    // Single byte into the prefetch ring
    typedef struct packed {
        logic       we;
        logic [7:0] data;
    } ring_wr_t;

endpackage

// File: verilog/dir_fetch.sv
`timescale 1ns/10ps
`include "dcu_defines.svh"

module dir_fetch (
    input  logic                CLK,
    input  logic                rst,
    input  dcu_pkg::dir_req_t   dir,
    output dcu_pkg::rom_req_t   rom_req,
    input  dcu_pkg::rom_rsp_t   rom_rsp,
    output dcu_pkg::dir_entry_t entry,
    output logic                done
);
    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_DRAIN} state_t;

    state_t                 state;
    logic [`DCU_PTR_W-1:0]  byte_addr;
    logic [1:0]             byte_idx;
    logic                   req_q;
    logic [`DCU_ROM_AW-1:0] req_addr;
    logic [1:0]             mode_q;
    logic [`DCU_PTR_W-1:0]  ptr_q;
    logic                   done_q;
    logic [7:0]             rom_byte;
    logic                   outstanding;

    // Even byte in the high half, odd byte in the low half
    assign rom_byte    = byte_addr[0] ? rom_rsp.data[7:0] : rom_rsp.data[15:8];
    assign outstanding = (state == S_WAIT) || (state == S_DRAIN);

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= S_IDLE;
            byte_addr <= '0;
            byte_idx  <= 2'd0;
            req_q     <= 1'b0;
            req_addr  <= '0;
            mode_q    <= 2'd0;
            ptr_q     <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (dir.start) begin
                // Entry sits at base + index * 4
                byte_addr <= dir.base + {dir.index, 2'b00};
                byte_idx  <= 2'd0;
                // A read in flight must finish before the new walk
                if (outstanding && !rom_rsp.ack) begin
                    state <= S_DRAIN;
                end else begin
                    state <= S_ISSUE;
                    req_q <= 1'b0;
                end
            end else begin
                case (state)
                    S_ISSUE: begin
                        req_q    <= 1'b1;
                        req_addr <= byte_addr[`DCU_PTR_W-1:1];
                        state    <= S_WAIT;
                    end
                    S_WAIT: begin
                        if (rom_rsp.ack) begin
                            req_q     <= 1'b0;
                            byte_addr <= byte_addr + 1'b1;
                            byte_idx  <= byte_idx + 2'd1;
                            // Byte 0 is mode, bytes 1 to 3 are the pointer MSB first
                            if (byte_idx == 2'd0) begin
                                mode_q <= rom_byte[1:0];
                            end else begin
                                ptr_q <= {ptr_q[15:0], rom_byte};
                            end
                            if (byte_idx == 2'd3) begin
                                done_q <= 1'b1;
                                state  <= S_IDLE;
                            end else begin
                                state <= S_ISSUE;
                            end
                        end
                    end
                    S_DRAIN: begin
                        // Stale word, dropped
                        if (rom_rsp.ack) begin
                            req_q <= 1'b0;
                            state <= S_ISSUE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign rom_req = '{req: req_q, addr: req_addr};
    assign entry   = '{mode: mode_q, ptr: ptr_q};
    assign done    = done_q;

endmodule

// File: verilog/host_regs.sv
`timescale 1ns/10ps
`include "dcu_defines.svh"

module host_regs (
    input  logic               CLK,
    input  logic               rst,
    input  dcu_pkg::host_req_t host,
    input  logic               ring_empty,
    input  logic [7:0]         ring_rdata,
    output logic               ring_rd,
    output dcu_pkg::dir_req_t  dir,
    output logic [7:0]         host_rdata
);
    logic [`DCU_PTR_W-1:0] base_q;
    logic [7:0]            index_q;
    logic [15:0]           length_q;
    logic                  start_q;
    logic [7:0]            rdata_q;
    logic                  data_rd;

    ////////////////////////////////////////
    // Data port pop
    ////////////////////////////////////////

    assign data_rd = host.rd && (host.port == `DCU_PORT_READ);
    // Every data port read pops the head byte
    assign ring_rd = data_rd;

    ////////////////////////////////////////
    // Register writes and read mux
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst) begin
            base_q   <= '0;
            index_q  <= 8'h00;
            length_q <= 16'h0000;
            start_q  <= 1'b0;
            rdata_q  <= 8'h00;
        end else begin
            // Index write kicks off a directory fetch
            start_q <= host.wr && (host.port == `DCU_PORT_INDEX);
            if (host.wr) begin
                case (host.port)
                    `DCU_PORT_BASE0:    base_q[7:0]    <= host.wdata;
                    `DCU_PORT_BASE1:    base_q[15:8]   <= host.wdata;
                    `DCU_PORT_BASE2:    base_q[23:16]  <= host.wdata;
                    `DCU_PORT_INDEX:    index_q        <= host.wdata;
                    `DCU_PORT_COUNTER0: length_q[7:0]  <= host.wdata;
                    `DCU_PORT_COUNTER1: length_q[15:8] <= host.wdata;
                    default: ;
                endcase
            end
            // Length counts every data port read
            if (data_rd) begin
                length_q <= length_q - 16'd1;
            end
            if (host.rd) begin
                case (host.port)
                    `DCU_PORT_READ:     rdata_q <= ring_rdata;
                    `DCU_PORT_BASE0:    rdata_q <= base_q[7:0];
                    `DCU_PORT_BASE1:    rdata_q <= base_q[15:8];
                    `DCU_PORT_BASE2:    rdata_q <= base_q[23:16];
                    `DCU_PORT_INDEX:    rdata_q <= index_q;
                    `DCU_PORT_COUNTER0: rdata_q <= length_q[7:0];
                    `DCU_PORT_COUNTER1: rdata_q <= length_q[15:8];
                    `DCU_PORT_STATUS:   rdata_q <= ring_empty ? 8'h00 : `DCU_STATUS_READY;
                    default:            rdata_q <= 8'h00;
                endcase
            end
        end
    end

    assign dir        = '{start: start_q, base: base_q, index: index_q};
    assign host_rdata = rdata_q;

endmodule

// File: verilog/rom_port.sv
`timescale 1ns/10ps
`include "dcu_defines.svh"

module rom_port (
    input  logic                   CLK,
    input  logic                   rst,
    input  dcu_pkg::rom_req_t      dir_req,
    input  dcu_pkg::rom_req_t      pf_req,
    output dcu_pkg::rom_rsp_t      dir_rsp,
    output dcu_pkg::rom_rsp_t      pf_rsp,
    input  logic                   rom_busy,
    output logic [`DCU_ROM_AW-1:0] rom_addr,
    output logic                   rom_rd,
    input  logic [15:0]            rom_data
);
    logic                   active;
    logic                   gnt_pf;
    logic [3:0]             wait_cnt;
    logic [`DCU_ROM_AW-1:0] addr_q;
    logic [15:0]            data_q;
    logic                   dir_ack;
    logic                   pf_ack;
    logic                   last_cycle;

    // Final unpreempted cycle of the access
    assign last_cycle = active && !rom_busy && (wait_cnt == 4'd1);

    always_ff @(posedge CLK) begin
        if (rst) begin
            active   <= 1'b0;
            gnt_pf   <= 1'b0;
            wait_cnt <= 4'd0;
            addr_q   <= '0;
            dir_ack  <= 1'b0;
            pf_ack   <= 1'b0;
        end else begin
            dir_ack <= 1'b0;
            pf_ack  <= 1'b0;
            if (!active) begin
                // Requests are still up during the ack cycle so skip it
                if (!dir_ack && !pf_ack && (dir_req.req || pf_req.req)) begin
                    active   <= 1'b1;
                    gnt_pf   <= !dir_req.req;
                    addr_q   <= dir_req.req ? dir_req.addr : pf_req.addr;
                    wait_cnt <= `DCU_ROM_WAIT;
                end
            end else if (rom_busy) begin
                // Higher priority reader took the bus, start over
                wait_cnt <= `DCU_ROM_WAIT;
            end else if (last_cycle) begin
                active  <= 1'b0;
                dir_ack <= !gnt_pf;
                pf_ack  <= gnt_pf;
            end else begin
                wait_cnt <= wait_cnt - 4'd1;
            end
        end
    end

    // Capture the ROM word as the wait expires
    always_ff @(posedge CLK) begin
        if (rst) begin
            data_q <= 16'h0000;
        end else if (last_cycle) begin
            data_q <= rom_data;
        end
    end

    assign rom_addr = addr_q;
    assign rom_rd   = active;
    assign dir_rsp  = '{ack: dir_ack, data: data_q};
    assign pf_rsp   = '{ack: pf_ack, data: data_q};

    // Clients hold req through the ack cycle
    a_dir_ack_req: assert property (@(posedge CLK) disable iff (rst) dir_ack |-> dir_req.req)
        else $error("rom_port: ack to dir_fetch without request");
    a_pf_ack_req: assert property (@(posedge CLK) disable iff (rst) pf_ack |-> pf_req.req)
        else $error("rom_port: ack to rom_prefetch without request");

endmodule

// File: verilog/rom_prefetch.sv
`timescale 1ns/10ps
`include "dcu_defines.svh"

module rom_prefetch (
    input  logic                CLK,
    input  logic                rst,
    input  logic                flush,
    input  logic                done,
    input  dcu_pkg::dir_entry_t entry,
    input  logic                ring_two_free,
    output dcu_pkg::rom_req_t   rom_req,
    input  dcu_pkg::rom_rsp_t   rom_rsp,
    output dcu_pkg::ring_wr_t   ring_wr
);
    typedef enum logic [2:0] {P_IDLE, P_CHECK, P_REQ, P_LOW, P_DRAIN} state_t;

    state_t                 state;
    logic [`DCU_PTR_W-1:0]  ptr_q;
    logic                   req_q;
    logic [`DCU_ROM_AW-1:0] req_addr;
    logic [7:0]             low_byte;
    dcu_pkg::ring_wr_t      wr_q;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state    <= P_IDLE;
            ptr_q    <= '0;
            req_q    <= 1'b0;
            req_addr <= '0;
            low_byte <= 8'h00;
            wr_q     <= '0;
        end else begin
            wr_q.we <= 1'b0;
            if (flush) begin
                // Let a pending ROM read complete, then throw it away
                if ((state == P_REQ || state == P_DRAIN) && !rom_rsp.ack) begin
                    state <= P_DRAIN;
                end else begin
                    state <= P_IDLE;
                    req_q <= 1'b0;
                end
            end else begin
                case (state)
                    P_IDLE: begin
                        if (done) begin
                            ptr_q <= entry.ptr;
                            state <= P_CHECK;
                        end
                    end
                    P_CHECK: begin
                        // Ring pointers lag a write issued this cycle
                        if (ring_two_free && !wr_q.we) begin
                            req_q    <= 1'b1;
                            req_addr <= ptr_q[`DCU_PTR_W-1:1];
                            state    <= P_REQ;
                        end
                    end
                    P_REQ: begin
                        if (rom_rsp.ack) begin
                            req_q    <= 1'b0;
                            low_byte <= rom_rsp.data[7:0];
                            wr_q.we  <= 1'b1;
                            ptr_q    <= ptr_q + 1'b1;
                            // Odd pointer only wants the low byte
                            if (ptr_q[0]) begin
                                wr_q.data <= rom_rsp.data[7:0];
                                state     <= P_CHECK;
                            end else begin
                                wr_q.data <= rom_rsp.data[15:8];
                                state     <= P_LOW;
                            end
                        end
                    end
                    P_LOW: begin
                        wr_q  <= '{we: 1'b1, data: low_byte};
                        ptr_q <= ptr_q + 1'b1;
                        state <= P_CHECK;
                    end
                    P_DRAIN: begin
                        if (rom_rsp.ack) begin
                            req_q <= 1'b0;
                            state <= P_IDLE;
                        end
                    end
                    default: state <= P_IDLE;
                endcase
            end
        end
    end

    assign rom_req = '{req: req_q, addr: req_addr};
    assign ring_wr = wr_q;

endmodule
